//--- source/fetch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch path widths, major opcodes and the packed
// structs shared by the frontend blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fetch_pkg;

    localparam int addr_w  = 64;          // virtual address width
    localparam int line_hw = 4;           // halfwords per memory line
    localparam int line_w  = 16 * line_hw; // line width in bits

    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // line request towards instruction memory
    typedef struct packed {
        logic [addr_w-1:0] addr;  // line aligned
        logic              epoch; // echoed back in the response
    } fetch_req_t;

    typedef struct packed {
        logic [line_w-1:0] data;
        logic              epoch;
    } fetch_resp_t;

    // instruction as cut out of the line window
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [31:0]       ir; // compressed form sits in bits 15:0
    } raw_inst_t;

    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [31:0]       ir;
        logic              compressed;
        logic              branch;
        logic              jal;    // also set for C.J
        logic              jalr;   // also set for C.JR / C.JALR
        logic              call;
        logic              ret;
        logic [addr_w-1:0] target; // static target or fall-through
    } inst_bundle_t;

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] pc;
    } redirect_t;

endpackage

`default_nettype wire

//--- source/fetch_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular FIFO with a type parameter for payload,
// valid/ready on both sides and a flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
)(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);
    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [idx_w-1:0] front;  // oldest entry
    logic [idx_w-1:0] tail;   // next free slot
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    always_comb out_valid = count != '0;
    always_comb out_data  = mem[front];
    always_comb pop       = out_valid & out_ready;
    always_comb in_ready  = (count != cnt_w'(depth)) | pop; // full queue takes a push on pop
    always_comb push      = in_valid & in_ready;

    // wrap front + count without needing a power of two depth
    always_comb begin
        if (int'(front) + int'(count) >= depth)
            tail = idx_w'(int'(front) + int'(count) - depth);
        else
            tail = idx_w'(int'(front) + int'(count));
    end

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            front <= '0;
            count <= '0;
        end else begin
            if (pop)
                front <= (int'(front) == depth - 1) ? '0 : front + 1'b1;
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[tail] <= in_data;
    end

endmodule

`default_nettype wire

//--- source/fetch_pc_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch PC generator: redirect merge, epoch and
// line requests limited by response credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen #(
    parameter logic [fetch_pkg::addr_w-1:0] rst_pc = 64'h0000_0000_8000_0000,
    parameter int resp_depth = 4
)(
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::redirect_t   be_redirect,
    input  fetch_pkg::redirect_t   jump_redirect,
    output fetch_pkg::redirect_t   flush,
    output fetch_pkg::fetch_req_t  mem_req,
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    input  logic                   line_pop
);
    localparam int aw    = fetch_pkg::addr_w;
    localparam int off_w = $clog2(2 * fetch_pkg::line_hw); // byte offset inside a line
    localparam int crd_w = $clog2(resp_depth + 1);
    localparam logic [aw-1:0] line_bytes = 2 * fetch_pkg::line_hw;

    logic [aw-1:0]    next_line; // address of the next line to request
    logic             epoch;
    logic             booting;   // first cycle out of reset
    logic [crd_w-1:0] credits;   // requests not yet popped from the response queue
    logic             req_fire;

    // backend wins over the pre-decoder, boot start comes last
    always_comb begin
        if (be_redirect.valid) begin
            flush = be_redirect;
        end else if (jump_redirect.valid) begin
            flush = jump_redirect;
        end else begin
            flush.valid = booting;
            flush.pc    = rst_pc;
        end
    end

    always_comb begin
        mem_req.addr  = next_line;
        mem_req.epoch = epoch;
    end

    always_comb mem_req_valid = ~booting & (credits < crd_w'(resp_depth));
    always_comb req_fire      = mem_req_valid & mem_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            booting <= 1'b1;
            epoch   <= 1'b0;
            credits <= '0;
        end else begin
            booting <= 1'b0;
            if (flush.valid)
                epoch <= ~epoch; // older responses become stale
            credits <= credits + crd_w'(req_fire) - crd_w'(line_pop);
        end
    end

    // boot start also passes through here while rst is high
    always_ff @(posedge clk) begin
        if (flush.valid)
            next_line <= {flush.pc[aw-1:off_w], {off_w{1'b0}}};
        else if (req_fire)
            next_line <= next_line + line_bytes;
    end

endmodule

`default_nettype wire

//--- source/fetch_line_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-line window that cuts one 16/32-bit
// instruction per cycle, with its PC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fetch_line_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::redirect_t   flush,
    input  fetch_pkg::fetch_resp_t line,
    input  logic                   line_valid,
    output logic                   line_ready,
    input  logic                   epoch,
    output fetch_pkg::raw_inst_t   inst,
    output logic                   inst_valid,
    input  logic                   inst_ready
);
    localparam int aw    = fetch_pkg::addr_w;
    localparam int lw    = fetch_pkg::line_w;
    localparam int lhw   = fetch_pkg::line_hw;
    localparam int cur_w = $clog2(lhw);
    localparam logic [aw-1:0] line_bytes = 2 * lhw;

    logic [lw-1:0]   d0, d1;     // current and next line
    logic            v0, v1;
    logic [lw-1:0]   n_d0, n_d1;
    logic            n_v0, n_v1;
    logic [aw-1:0]   line_pc;    // address of d0
    logic [cur_w-1:0] cursor;    // halfword index inside d0
    logic [2*lw-1:0] window;
    logic [15:0]     hw0, hw1;
    logic            is32;
    logic [cur_w:0]  new_pos;
    logic            stale;
    logic            take;
    logic            fire;
    logic            retire;

    always_comb begin
        window = {d1, d0};
        hw0    = window[16*int'(cursor) +: 16];
        hw1    = window[16*(int'(cursor) + 1) +: 16]; // may reach into d1
        is32   = hw0[1:0] == 2'b11;
    end

    // a 32-bit instruction on the last halfword waits for the next line
    always_comb inst_valid = v0 & (~is32 | (int'(cursor) != lhw - 1) | v1);

    always_comb begin
        inst.pc = line_pc + aw'({cursor, 1'b0});
        inst.ir = is32 ? {hw1, hw0} : {16'h0000, hw0};
    end

    always_comb begin
        fire    = inst_valid & inst_ready;
        new_pos = {1'b0, cursor} + (is32 ? (cur_w+1)'(2) : (cur_w+1)'(1));
        retire  = fire & (int'(new_pos) >= lhw);
    end

    // stale lines are always popped and thrown away
    always_comb begin
        stale      = line.epoch != epoch;
        line_ready = stale | ~v1;
        take       = line_valid & line_ready & ~stale;
    end

    always_comb begin
        n_v0 = v0;
        n_v1 = v1;
        n_d0 = d0;
        n_d1 = d1;
        if (retire) begin // shift next line down
            n_v0 = v1;
            n_v1 = 1'b0;
            n_d0 = d1;
        end
        if (take) begin
            if (!n_v0) begin
                n_v0 = 1'b1;
                n_d0 = line.data;
            end else begin
                n_v1 = 1'b1;
                n_d1 = line.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v0     <= 1'b0;
            v1     <= 1'b0;
            cursor <= '0;
        end else if (flush.valid) begin
            v0     <= 1'b0;
            v1     <= 1'b0;
            cursor <= flush.pc[cur_w:1]; // restart mid-line
        end else begin
            v0 <= n_v0;
            v1 <= n_v1;
            if (fire)
                cursor <= new_pos[cur_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        d0 <= n_d0;
        d1 <= n_d1;
        if (flush.valid)
            line_pc <= {flush.pc[aw-1:cur_w+1], {(cur_w+1){1'b0}}};
        else if (retire)
            line_pc <= line_pc + line_bytes;
    end

endmodule

`default_nettype wire

//--- source/predecode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pre-decoder: control flow class, call/ret, static
// target and redirect at unconditional direct jumps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module predecode (
    input  fetch_pkg::raw_inst_t    raw,
    input  logic                    raw_valid,
    output logic                    raw_ready,
    output fetch_pkg::inst_bundle_t bundle,
    output logic                    bundle_valid,
    input  logic                    bundle_ready,
    output fetch_pkg::redirect_t    jump_redirect
);
    localparam int aw = fetch_pkg::addr_w;

    logic [31:0]   ir;
    logic [4:0]    rd, rs1;
    logic          comp;
    logic          branch, jal, jalr, call, ret;
    logic [aw-1:0] target;

    function automatic logic is_link(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    always_comb begin
        ir   = raw.ir;
        rd   = ir[11:7];
        rs1  = ir[19:15];
        comp = ir[1:0] != 2'b11;

        branch = ~comp & (ir[6:0] == fetch_pkg::op_branch);
        jal    = ~comp & (ir[6:0] == fetch_pkg::op_jal);
        jalr   = ~comp & (ir[6:0] == fetch_pkg::op_jalr);
        call   = (jal | jalr) & is_link(rd);
        ret    = jalr & is_link(rs1) & (rs1 != rd); // rd == rs1 is a call only

        target = raw.pc + (comp ? aw'(2) : aw'(4)); // fall-through
        if (branch)
            target = raw.pc + {{(aw-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
        if (jal)
            target = raw.pc + {{(aw-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

        if (ir[15:13] == 3'b101 && ir[1:0] == 2'b01) begin // C.J
            jal    = 1'b1;
            target = raw.pc + {{(aw-11){ir[12]}}, ir[8], ir[10:9], ir[6], ir[7],
                               ir[2], ir[11], ir[5:3], 1'b0};
        end
        if (ir[15:14] == 2'b11 && ir[1:0] == 2'b01) begin // C.BEQZ / C.BNEZ
            branch = 1'b1;
            target = raw.pc + {{(aw-8){ir[12]}}, ir[6:5], ir[2], ir[11:10], ir[4:3], 1'b0};
        end
        // C.JR / C.JALR, rs1 of zero is C.EBREAK or reserved
        if (ir[15:13] == 3'b100 && ir[1:0] == 2'b10 && ir[6:2] == 5'd0 && rd != 5'd0) begin
            jalr = 1'b1;
            call = ir[12];
            ret  = (rd == 5'd1 && !ir[12]) || rd == 5'd5;
        end
    end

    always_comb begin
        bundle.pc         = raw.pc;
        bundle.ir         = raw.ir;
        bundle.compressed = comp;
        bundle.branch     = branch;
        bundle.jal        = jal;
        bundle.jalr       = jalr;
        bundle.call       = call;
        bundle.ret        = ret;
        bundle.target     = target;
    end

    always_comb begin
        bundle_valid = raw_valid;
        raw_ready    = bundle_ready;
    end

    // only taken once the jump itself is in the queue
    always_comb begin
        jump_redirect.valid = jal & raw_valid & bundle_ready;
        jump_redirect.pc    = target;
    end

endmodule

`default_nettype wire

//--- source/frontend_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frontend top: PC generator, response and
// instruction queues, line buffer, pre-decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
    parameter logic [fetch_pkg::addr_w-1:0] rst_pc = 64'h0000_0000_8000_0000,
    parameter int resp_depth = 4,
    parameter int iq_depth   = 8
)(
    input  logic                    clk,
    input  logic                    rst,
    output fetch_pkg::fetch_req_t   mem_req,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,
    input  fetch_pkg::fetch_resp_t  mem_resp,
    input  logic                    mem_resp_valid,
    output logic                    mem_resp_ready,
    output fetch_pkg::inst_bundle_t out,
    output logic                    out_valid,
    input  logic                    out_ready,
    input  fetch_pkg::redirect_t    be_redirect
);
    fetch_pkg::redirect_t    flush;
    fetch_pkg::redirect_t    jump_redirect;
    fetch_pkg::fetch_resp_t  line;
    logic                    line_valid, line_ready;
    fetch_pkg::raw_inst_t    raw;
    logic                    raw_valid, raw_ready;
    fetch_pkg::inst_bundle_t bundle;
    logic                    bundle_valid, bundle_ready;

    fetch_pc_gen #(.rst_pc(rst_pc), .resp_depth(resp_depth)) u_pc_gen (
        .clk(clk), .rst(rst),
        .be_redirect(be_redirect), .jump_redirect(jump_redirect), .flush(flush),
        .mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .line_pop(line_valid & line_ready)  // one credit back per popped line
    );

    // stale lines drain through the epoch check so every credit comes back
    fetch_queue #(.payload_t(fetch_pkg::fetch_resp_t), .depth(resp_depth)) u_resp_q (
        .clk(clk), .rst(rst), .flush(1'b0),
        .in_data(mem_resp), .in_valid(mem_resp_valid), .in_ready(mem_resp_ready),
        .out_data(line), .out_valid(line_valid), .out_ready(line_ready)
    );

    fetch_line_buffer u_line_buf (
        .clk(clk), .rst(rst), .flush(flush),
        .line(line), .line_valid(line_valid), .line_ready(line_ready),
        .epoch(mem_req.epoch),
        .inst(raw), .inst_valid(raw_valid), .inst_ready(raw_ready)
    );

    predecode u_predecode (
        .raw(raw), .raw_valid(raw_valid), .raw_ready(raw_ready),
        .bundle(bundle), .bundle_valid(bundle_valid), .bundle_ready(bundle_ready),
        .jump_redirect(jump_redirect)
    );

    // queued instructions before a jump stay on the right path
    fetch_queue #(.payload_t(fetch_pkg::inst_bundle_t), .depth(iq_depth)) u_inst_q (
        .clk(clk), .rst(rst), .flush(be_redirect.valid),
        .in_data(bundle), .in_valid(bundle_valid), .in_ready(bundle_ready),
        .out_data(out), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns  = 100,
    parameter int rst_cycles = 2
)(
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0; // released on an edge like every other input
    end

endmodule

`default_nettype wire

//--- tests/frontend_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake assertions bound into frontend_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frontend_properties (
    input logic                    clk,
    input logic                    rst,
    input fetch_pkg::fetch_req_t   mem_req,
    input logic                    mem_req_valid,
    input logic                    mem_req_ready,
    input logic                    mem_resp_valid,
    input logic                    mem_resp_ready,
    input logic                    line_valid,
    input logic                    raw_valid,
    input fetch_pkg::inst_bundle_t out,
    input logic                    out_valid,
    input logic                    out_ready,
    input fetch_pkg::redirect_t    be_redirect,
    input fetch_pkg::redirect_t    flush
);
    // a backend redirect empties the queue even under a stalled output
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !be_redirect.valid |=> out_valid && $stable(out))
        else $error("out dropped or changed while stalled");

    req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready && !flush.valid
        |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req dropped or changed while stalled");

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !mem_req_valid && !out_valid && !line_valid && !raw_valid)
        else $error("valid high in the cycle after reset");

    resp_taken: assert property (@(posedge clk) disable iff (rst)
        mem_resp_valid |-> mem_resp_ready)
        else $error("response queue refused a memory response");

endmodule

bind frontend_top frontend_properties u_props (.*);

`default_nettype wire

//--- tests/frontend_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frontend testbench: program memory model, reference
// walk of the program, output compare, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;
    localparam logic [63:0] start_pc = 64'h0000_0000_8000_0000;
    localparam int resp_depth = 4;
    localparam int iq_depth   = 8;
    localparam int prog_hw    = 128; // program halfwords
    localparam int max_lat    = 6;   // worst memory delay in cycles

    logic                    clk;
    logic                    rst;
    fetch_pkg::fetch_req_t   mem_req;
    logic                    mem_req_valid;
    logic                    mem_req_ready = 1'b0;
    fetch_pkg::fetch_resp_t  mem_resp = '0;
    logic                    mem_resp_valid = 1'b0;
    logic                    mem_resp_ready;
    fetch_pkg::inst_bundle_t out;
    logic                    out_valid;
    logic                    out_ready = 1'b0;
    fetch_pkg::redirect_t    be_redirect = '0;

    logic [15:0]             prog [prog_hw];
    int                      wp;
    logic [63:0]             redir_pc;
    logic [63:0]             end_pc;
    fetch_pkg::inst_bundle_t exp_q [$];
    fetch_pkg::fetch_req_t   pend_req [$];
    int                      pend_due [$];
    int                      cycle;
    int                      phase = 0; // 0 boot stream, 1 after redirect, 2 done
    int                      timeout_cycles = 0;
    int unsigned             seed = 32'h48463bef;

    tb_clock #(.period_ns(100), .rst_cycles(2)) u_clock (.clk(clk), .rst(rst));

    frontend_top #(
        .rst_pc(start_pc), .resp_depth(resp_depth), .iq_depth(iq_depth)
    ) u_dut (.*);

    function automatic logic [15:0] fill_hw(input logic [63:0] a);
        return a[15:0] ^ a[31:16] ^ a[47:32] ^ a[63:48] ^ 16'h5a5a;
    endfunction

    function automatic logic [15:0] read_hw(input logic [63:0] a);
        logic [63:0] idx;
        idx = (a - start_pc) >> 1;
        if (a >= start_pc && idx < prog_hw)
            return prog[idx];
        return fill_hw(a); // outside the program
    endfunction

    function automatic logic [fetch_pkg::line_w-1:0] line_data(input logic [63:0] addr);
        logic [fetch_pkg::line_w-1:0] d;
        for (int i = 0; i < fetch_pkg::line_hw; i++)
            d[16*i +: 16] = read_hw(addr + 64'(2 * i));
        return d;
    endfunction

    // expected bundle for the instruction stored at pc
    function automatic fetch_pkg::inst_bundle_t expect_at(input logic [63:0] pc);
        fetch_pkg::inst_bundle_t b;
        logic [31:0] ir;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic        rd_link;
        logic        rs1_link;
        ir = {read_hw(pc + 64'd2), read_hw(pc)};
        b = '0;
        b.pc = pc;
        b.compressed = ir[1:0] != 2'b11;
        if (b.compressed)
            ir[31:16] = 16'h0000;
        b.ir = ir;
        b.target = pc + (b.compressed ? 64'd2 : 64'd4); // next sequential pc
        rd = ir[11:7];
        rs1 = ir[19:15];
        rd_link = rd == 5'd1 || rd == 5'd5;
        rs1_link = rs1 == 5'd1 || rs1 == 5'd5;
        if (!b.compressed) begin
            if (ir[6:0] == fetch_pkg::op_branch) begin
                b.branch = 1'b1;
                b.target = pc + {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            end else if (ir[6:0] == fetch_pkg::op_jal) begin
                b.jal = 1'b1;
                b.call = rd_link;
                b.target = pc + {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            end else if (ir[6:0] == fetch_pkg::op_jalr) begin
                b.jalr = 1'b1;
                b.call = rd_link;
                b.ret = rs1_link && !(rd_link && rd == rs1); // same link reg is a call
            end
        end else if (ir[1:0] == 2'b01 && ir[15:13] == 3'b101) begin
            b.jal = 1'b1; // C.J
            b.target = pc + {{52{ir[12]}}, ir[12], ir[8], ir[10:9], ir[6], ir[7],
                             ir[2], ir[11], ir[5:3], 1'b0};
        end else if (ir[1:0] == 2'b01 && ir[15:14] == 2'b11) begin
            b.branch = 1'b1; // C.BEQZ, C.BNEZ
            b.target = pc + {{55{ir[12]}}, ir[12], ir[6:5], ir[2], ir[11:10], ir[4:3], 1'b0};
        end else if (ir[1:0] == 2'b10 && ir[15:13] == 3'b100 && ir[6:2] == 5'd0
                     && rd != 5'd0) begin
            b.jalr = 1'b1;
            b.call = ir[12]; // C.JALR links x1
            b.ret = ir[12] ? rd == 5'd5 : rd_link;
        end
        return b;
    endfunction

    task automatic put(input logic [31:0] w);
        prog[wp] = w[15:0];
        wp++;
        if (w[1:0] == 2'b11) begin
            prog[wp] = w[31:16];
            wp++;
        end
    endtask

    // refill exp_q with the in-order stream that starts at from_pc
    task automatic walk(input logic [63:0] from_pc);
        fetch_pkg::inst_bundle_t b;
        logic [63:0] pc;
        pc = from_pc;
        exp_q.delete();
        while (pc != end_pc && exp_q.size() < 100) begin
            b = expect_at(pc);
            exp_q.push_back(b);
            pc = b.jal ? b.target : b.pc + (b.compressed ? 64'd2 : 64'd4);
        end
    endtask

    task automatic build_program();
        for (int i = 0; i < prog_hw; i++)
            prog[i] = fill_hw(start_pc + 64'(2 * i));
        wp = 0;
        put(32'h00100093);        // addi x1, x0, 1
        put(32'h00208113);
        put(32'h00310193);
        put(32'h00418213);
        put(32'h00000505);        // c.addi x10, 1
        redir_pc = start_pc + 64'(2 * wp); // mid-line halfword
        put(32'h00520293);
        put(32'h00628313);        // crosses into the next line
        put(32'h00000585);
        put(32'h00004501);        // c.li x10, 0
        put(32'h00730393);        // crosses a line too
        put(32'h00208463);        // beq x1, x2, +8
        put(32'h0000c019);        // c.beqz x8, +6
        put(32'hfe209ee3);        // bne x1, x2, -4
        put(32'h0000fcfd);        // c.bnez x9, -2
        put(32'h00008067);        // jalr x0, 0(x1)
        put(32'h000280e7);        // jalr x1, 0(x5)
        put(32'h000282e7);        // jalr x5, 0(x5)
        put(32'h00008082);        // c.jr x1
        put(32'h00009282);        // c.jalr x5
        put(32'h00009082);        // c.jalr x1
        put(32'h00008282);        // c.jr x5
        put(32'h00a000ef);        // jal x1, +10
        for (int i = 0; i < 3; i++)
            put(32'h00000505);    // skipped by the jal
        put(32'h0000a019);        // c.j +6
        put(32'h00100093);        // skipped by the c.j
        put(32'h00a00513);
        put(32'h00000505);
        end_pc = start_pc + 64'(2 * wp);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "output stream mismatch");
        end
    endtask

    // in-order line memory with random accept and random latency
    always @(posedge clk) begin : memory_model
        fetch_pkg::fetch_resp_t r;
        if (rst) begin
            mem_req_ready  <= 1'b0;
            mem_resp_valid <= 1'b0;
            pend_req.delete();
            pend_due.delete();
            cycle = 0;
        end else begin
            cycle++;
            if (mem_req_valid && mem_req_ready) begin
                pend_req.push_back(mem_req);
                pend_due.push_back(cycle + int'($urandom_range(1, max_lat)));
            end
            if (!mem_resp_valid || mem_resp_ready) begin
                if (pend_req.size() != 0 && pend_due[0] <= cycle) begin
                    r.data  = line_data(pend_req[0].addr);
                    r.epoch = pend_req[0].epoch; // echoed
                    mem_resp       <= r;
                    mem_resp_valid <= 1'b1;
                    void'(pend_req.pop_front());
                    void'(pend_due.pop_front());
                end else begin
                    mem_resp_valid <= 1'b0;
                end
            end
            mem_req_ready <= $urandom_range(0, 3) != 0;
        end
    end

    always @(posedge clk) begin : compare_and_drive
        fetch_pkg::inst_bundle_t e;
        if (rst) begin
            out_ready   <= 1'b0;
            be_redirect <= '0;
        end else begin
            be_redirect <= '0;
            if (out_valid && out_ready) begin
                e = exp_q.pop_front();
                check_value("out.pc", out.pc, e.pc);
                check_value("out.ir", 64'(out.ir), 64'(e.ir));
                check_value("out.flags", 64'({out.compressed, out.branch, out.jal,
                    out.jalr, out.call, out.ret}), 64'({e.compressed, e.branch, e.jal,
                    e.jalr, e.call, e.ret}));
                check_value("out.target", out.target, e.target);
            end
            if (phase == 0 && exp_q.size() == 0) begin
                be_redirect <= {1'b1, redir_pc}; // lines still in flight here
                out_ready   <= 1'b0;
                walk(redir_pc);
                phase = 1;
            end else begin
                if (phase == 1 && exp_q.size() == 0)
                    phase = 2;
                out_ready <= (exp_q.size() != 0) && ($urandom_range(0, 3) != 0);
            end
        end
    end

    initial begin
        int n_after;
        void'($urandom(seed));
        build_program();
        walk(redir_pc);
        n_after = exp_q.size();
        walk(start_pc);
        repeat (3) void'(exp_q.pop_back()); // redirect while the DUT runs ahead
        timeout_cycles = (exp_q.size() + n_after) * (max_lat + 8) * 4 + 200;
        wait (phase == 2);
        repeat (4) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

    initial begin : watchdog
        wait (timeout_cycles != 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("Something failed");
        $fatal(1, "timeout: the instruction stream stopped before all expected entries");
    end

endmodule

`default_nettype wire

//--- project.f
source/fetch_pkg.sv
source/fetch_queue.sv
source/fetch_pc_gen.sv
source/fetch_line_buffer.sv
source/predecode.sv
source/frontend_top.sv
tests/tb_clock.sv
tests/frontend_properties.sv
tests/frontend_tb.sv
